/* test/box_stim.hex */
// Per frame: 14 rows of 16 pixels, column 0 in the top byte.
// Then 8 expected windows in raster order: {win_sum[15:0], centre[7:0]}.
4821863B732A5E19804F358C62277741
8B64C97EB66DA15CC39278CFA56ABA84
340D72275F164A056C3B21784E13632D
724BB0659D548843AA795FB68C51A16B
A37CE196CE85B974DBAA90E7BD82D29C
5D369B50883F732E95644AA1773C8C56
3F187D326A21551077462C83591E6E38
9770D58AC279AD68CF9E84DBB176C690
6A43A85D954C803BA27157AE84499963
7E57BC71A960944FB6856BC2985DAD77
522B90457D3468238A593F966C31814B
A982E79CD48BBF7AE1B096EDC388D8A2
3912772C641B4F0A7140267D53186832
845DC277AF669A55BC8B71C89E63B37D
4D5755
4BAA10
500877
4C8746
5063AD
4EB668
5314CF
4F939E
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF
A857FF
A857FF
A857FF
A857FF
A857FF
A857FF
A857FF
A857FF

/* compile.f */
hw/img_pkg.sv
hw/ctrl_pkg.sv
hw/column_buffer.sv
hw/scan_ctrl.sv
hw/r6_window_sum.sv
hw/box_filter_top.sv
test/tb_box_filter.sv

/* test/tb_box_filter.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_box_filter;

  import img_pkg::*;

  localparam real CLK_PERIOD  = 4.0;
  localparam int  RST_CYCLES  = 8;
  localparam int  N_FRAMES    = 2;
  localparam int  N_WIN       = 8;  // Full windows per frame.
  localparam int  FRAME_LINES = FRAME_ROWS + N_WIN;
  localparam int  FRAME_PIX   = FRAME_COLS * FRAME_ROWS;
  localparam int  WDOG_CYCLES = N_FRAMES * FRAME_PIX + 50;

  logic     clk;
  logic     rst_n;
  pixel_t   i_pix;
  logic     i_pix_valid;
  logic     i_sof;
  win_sum_t o_win_sum;
  pixel_t   o_centre;
  logic     o_win_valid;
  logic     o_frame_done;

  // Pixel rows, then expected {sum, centre} words, per frame.
  logic [127:0] stim_mem [N_FRAMES*FRAME_LINES];

  logic reset_test_done = 1'b0;
  int   checks          = 0;
  int   errors          = 0;
  int   quiet_cycles    = 0;
  int   mon_frame       = 0;
  int   win_count       = 0;
  int   frame_errors    = 0;

  box_filter_top box_filter_top_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_pix        (i_pix),
    .i_pix_valid  (i_pix_valid),
    .i_sof        (i_sof),
    .o_win_sum    (o_win_sum),
    .o_centre     (o_centre),
    .o_win_valid  (o_win_valid),
    .o_frame_done (o_frame_done)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2.0) clk = ~clk;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Checking
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic count_error();
    errors++;
    frame_errors++;
  endtask

  task automatic check_quiet();
    checks += 2;
    quiet_cycles++;
    assert (o_win_valid === 1'b0) else begin
      $display("FAILED o_win_valid around reset: got %h, expected 0", o_win_valid);
      count_error();
    end
    assert (o_frame_done === 1'b0) else begin
      $display("FAILED o_frame_done around reset: got %h, expected 0", o_frame_done);
      count_error();
    end
  endtask

  task automatic check_window();
    logic [23:0] exp_word;
    win_sum_t    exp_sum;
    pixel_t      exp_centre;
    if (mon_frame >= N_FRAMES || win_count >= N_WIN) begin
      $display("Window strobe %0d in frame %0d is more than the frame holds",
               win_count + 1, mon_frame + 1);
      count_error();
    end else begin
      exp_word   = stim_mem[mon_frame*FRAME_LINES + FRAME_ROWS + win_count][23:0];
      exp_sum    = exp_word[23:8];
      exp_centre = exp_word[7:0];
      checks += 2;
      assert (o_win_sum === exp_sum) else begin
        $display("FAILED o_win_sum frame %0d window %0d: got %h, expected %h",
                 mon_frame + 1, win_count, o_win_sum, exp_sum);
        count_error();
      end
      assert (o_centre === exp_centre) else begin
        $display("FAILED o_centre frame %0d window %0d: got %h, expected %h",
                 mon_frame + 1, win_count, o_centre, exp_centre);
        count_error();
      end
    end
    win_count++;
  endtask

  task automatic end_frame();
    checks++;
    assert (win_count == N_WIN) else begin
      $display("Frame %0d ended after %0d window strobes instead of %0d",
               mon_frame + 1, win_count, N_WIN);
      count_error();
    end
    $display("frame %0d: %0d windows seen, %0d errors", mon_frame + 1, win_count, frame_errors);
    mon_frame++;
    win_count    = 0;
    frame_errors = 0;
  endtask

  // Outputs settle mid-cycle.
  always @(negedge clk) begin
    if (!reset_test_done) begin
      check_quiet();
    end else begin
      if (o_win_valid) check_window();
      if (o_frame_done) begin
        if (mon_frame >= N_FRAMES) begin
          $display("Frame done pulse arrived with no frame in progress");
          count_error();
        end else begin
          end_frame();
        end
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Stimulus
  // ~~~~~~~~~~~~~~~~~~~~

  task automatic send_frame(input int f);
    logic [127:0] row;
    for (int r = 0; r < FRAME_ROWS; r++) begin
      row = stim_mem[f*FRAME_LINES + r];
      for (int c = 0; c < FRAME_COLS; c++) begin
        i_pix       <= row[127-8*c -: 8];  // Column 0 in the top byte.
        i_pix_valid <= 1'b1;
        i_sof       <= (r == 0 && c == 0);
        @(posedge clk);
      end
    end
  endtask

  initial begin
    rst_n       = 1'b0;
    i_pix       = '0;
    i_pix_valid = 1'b0;
    i_sof       = 1'b0;
    $readmemh("test/box_stim.hex", stim_mem);
    checks++;
    assert (!$isunknown(stim_mem[N_FRAMES*FRAME_LINES-1])) else begin
      $display("Stimulus file test/box_stim.hex is missing or too short");
      errors++;
    end

    repeat (RST_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    repeat (3) @(posedge clk);
    reset_test_done = 1'b1;
    $display("reset: %0d cycles checked quiet, %0d errors", quiet_cycles, errors);

    // Frames run back to back with no idle cycle.
    for (int f = 0; f < N_FRAMES; f++) begin
      send_frame(f);
    end
    i_pix       <= '0;
    i_pix_valid <= 1'b0;
    i_sof       <= 1'b0;

    wait (mon_frame == N_FRAMES);
    repeat (4) @(posedge clk);  // Catch stray strobes.
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Watchdog
  // ~~~~~~~~~~~~~~~~~~~~

  initial begin
    repeat (WDOG_CYCLES) @(posedge clk);
    $display("Timeout: frames not finished after %0d clock cycles", WDOG_CYCLES);
    $display("Test FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* hw/box_filter_top.sv */
`timescale 1ns/1ps
`default_nettype none

module box_filter_top (
  input  logic              clk,
  input  logic              rst_n,
  input  img_pkg::pixel_t   i_pix,
  input  logic              i_pix_valid,
  input  logic              i_sof,
  output img_pkg::win_sum_t o_win_sum,
  output img_pkg::pixel_t   o_centre,
  output logic              o_win_valid,
  output logic              o_frame_done
);

  import img_pkg::*;
  import ctrl_pkg::*;

  pixel_t [WIN_SIZE-1:0] column;
  win_ctrl_t             win_ctrl;

  scan_ctrl scan_ctrl_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .i_pix_valid  (i_pix_valid),
    .i_sof        (i_sof),
    .o_ctrl       (win_ctrl),
    .o_frame_done (o_frame_done)
  );

  column_buffer column_buffer_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_pix       (i_pix),
    .i_pix_valid (i_pix_valid),
    .o_column    (column)
  );

  // Sum and centre come out COL_TREE_LAT + 1 after the last pixel.
  r6_window_sum r6_window_sum_inst (
    .clk         (clk),
    .rst_n       (rst_n),
    .i_column    (column),
    .i_ctrl      (win_ctrl),
    .o_win_sum   (o_win_sum),
    .o_centre    (o_centre),
    .o_win_valid (o_win_valid)
  );

endmodule

`default_nettype wire

/* hw/r6_window_sum.sv */
`timescale 1ns/1ps
`default_nettype none

module r6_window_sum (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  img_pkg::pixel_t [img_pkg::WIN_SIZE-1:0] i_column,
  input  ctrl_pkg::win_ctrl_t                     i_ctrl,
  output img_pkg::win_sum_t                       o_win_sum,
  output img_pkg::pixel_t                         o_centre,
  output logic                                    o_win_valid
);

  import img_pkg::*;
  import ctrl_pkg::*;

  localparam int N_PAIRS    = WIN_SIZE / 2;
  localparam int CENTRE_LAT = WIN_RADIUS + COL_TREE_LAT + 1;

  pixel_t [WIN_SIZE-1:0] taps_q;
  logic   [8:0]          lvl1_q [N_PAIRS];
  logic   [9:0]          lvl2_q [N_PAIRS/2];
  logic   [10:0]         lvl3_lo_q;
  logic   [10:0]         lvl3_hi_q;
  pixel_t                odd_d1_q;
  pixel_t                odd_d2_q;
  col_sum_t              col_sum_q;
  col_sum_t              col_dly_q [WIN_SIZE];
  col_sum_t              col_old;
  win_sum_t              sub_term;
  win_sum_t              acc_q;
  logic                  win_valid_q;
  pixel_t                centre_q [CENTRE_LAT];

  // ~~~~~~~~~~~~~~~~~~~~
  // Column adder tree
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    taps_q <= i_column;

    for (int i = 0; i < N_PAIRS; i++) begin
      lvl1_q[i] <= 9'(taps_q[2*i]) + 9'(taps_q[2*i+1]);
    end
    odd_d1_q <= taps_q[WIN_SIZE-1];  // Odd tap skips level one.

    for (int i = 0; i < N_PAIRS/2; i++) begin
      lvl2_q[i] <= 10'(lvl1_q[2*i]) + 10'(lvl1_q[2*i+1]);
    end
    odd_d2_q <= odd_d1_q;

    lvl3_lo_q <= 11'(lvl2_q[0]) + 11'(lvl2_q[1]);  // Rows 0..7.
    lvl3_hi_q <= 11'(lvl2_q[2]) + 11'(odd_d2_q);   // Rows 8..12.

    col_sum_q <= col_sum_t'(lvl3_lo_q) + col_sum_t'(lvl3_hi_q);
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Sliding window
  // ~~~~~~~~~~~~~~~~~~~~

  // Column sums of the last 13 positions.
  always_ff @(posedge clk) begin
    col_dly_q[0] <= col_sum_q;
    for (int k = 1; k < WIN_SIZE; k++) begin
      col_dly_q[k] <= col_dly_q[k-1];
    end
  end

  assign col_old  = col_dly_q[WIN_SIZE-1];
  assign sub_term = i_ctrl.sub ? win_sum_t'(col_old) : win_sum_t'(0);

  always_ff @(posedge clk) begin
    if (i_ctrl.ld) begin
      acc_q <= win_sum_t'(col_sum_q);  // First column of a row.
    end else begin
      acc_q <= acc_q + win_sum_t'(col_sum_q) - sub_term;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      win_valid_q <= 1'b0;
    end else begin
      win_valid_q <= i_ctrl.valid;
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Central pixel
  // ~~~~~~~~~~~~~~~~~~~~

  // Middle row tap, held back six columns plus the sum latency.
  always_ff @(posedge clk) begin
    centre_q[0] <= i_column[WIN_RADIUS];
    for (int k = 1; k < CENTRE_LAT; k++) begin
      centre_q[k] <= centre_q[k-1];
    end
  end

  assign o_win_sum   = acc_q;
  assign o_centre    = centre_q[CENTRE_LAT-1];
  assign o_win_valid = win_valid_q;

  // Dropped column was added earlier in the same row.
  a_acc_no_underflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    (i_ctrl.sub && !i_ctrl.ld) |->
      (17'(acc_q) + 17'(col_sum_q)) >= 17'(col_old)
  );

endmodule

`default_nettype wire

/* hw/scan_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

module scan_ctrl (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                i_pix_valid,
  input  logic                i_sof,
  output ctrl_pkg::win_ctrl_t o_ctrl,
  output logic                o_frame_done
);

  import img_pkg::*;
  import ctrl_pkg::*;

  // Done trails the last valid strobe by one cycle.
  localparam int DONE_LAT = COL_TREE_LAT + 2;

  scan_state_t state_q;
  scan_state_t state_nxt;
  scan_state_t cur_state;
  col_t        col_q;
  col_t        cur_col;
  row_t        row_q;
  row_t        cur_row;
  logic        active;
  logic        row_end;
  logic        last_pix;
  win_ctrl_t   ctrl_dec;

  win_ctrl_t [COL_TREE_LAT-1:0] ctrl_pipe_q;
  logic      [DONE_LAT-1:0]     done_pipe_q;

  // ~~~~~~~~~~~~~~~~~~~~
  // Position of the input pixel
  // ~~~~~~~~~~~~~~~~~~~~

  // Start of frame forces position (0,0).
  always_comb begin
    cur_state = i_sof ? FILL : state_q;
    cur_col   = i_sof ? col_t'(0) : col_q;
    cur_row   = i_sof ? row_t'(0) : row_q;
  end

  assign active   = i_pix_valid && (cur_state != IDLE);
  assign row_end  = (cur_col == col_t'(FRAME_COLS - 1));
  assign last_pix = row_end && (cur_row == row_t'(FRAME_ROWS - 1));

  always_comb begin
    state_nxt = state_q;
    if (active) begin
      state_nxt = cur_state;
      case (cur_state)
        FILL: begin
          if (row_end && (cur_row == row_t'(WIN_SIZE - 2))) state_nxt = SCAN;
        end
        SCAN: begin
          if (last_pix) state_nxt = IDLE;
        end
        default: state_nxt = IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state_q <= IDLE;
      col_q   <= '0;
      row_q   <= '0;
    end else begin
      state_q <= state_nxt;
      if (active) begin
        col_q <= row_end ? col_t'(0) : cur_col + 1'b1;
        if (last_pix) row_q <= '0;
        else if (row_end) row_q <= cur_row + 1'b1;
        else row_q <= cur_row;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Control decode and alignment
  // ~~~~~~~~~~~~~~~~~~~~

  always_comb begin
    ctrl_dec.ld    = active && (cur_col == col_t'(0));
    ctrl_dec.sub   = active && (cur_col >= col_t'(WIN_SIZE));
    ctrl_dec.valid = active && (cur_state == SCAN) && (cur_col >= col_t'(WIN_SIZE - 1));
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl_pipe_q <= '0;
      done_pipe_q <= '0;
    end else begin
      ctrl_pipe_q <= {ctrl_pipe_q[COL_TREE_LAT-2:0], ctrl_dec};  // Matches adder tree.
      done_pipe_q <= {done_pipe_q[DONE_LAT-2:0], active && last_pix};
    end
  end

  assign o_ctrl       = ctrl_pipe_q[COL_TREE_LAT-1];
  assign o_frame_done = done_pipe_q[DONE_LAT-1];

  a_sof_has_pixel : assert property (
    @(posedge clk) disable iff (!rst_n)
    i_sof |-> i_pix_valid
  );

  // Line buffers assume an unbroken stream inside a frame.
  a_no_gap : assert property (
    @(posedge clk) disable iff (!rst_n)
    (state_q != IDLE) |-> i_pix_valid
  );

endmodule

`default_nettype wire

/* hw/column_buffer.sv */
`timescale 1ns/1ps
`default_nettype none

module column_buffer (
  input  logic                                    clk,
  input  logic                                    rst_n,
  input  img_pkg::pixel_t                         i_pix,
  input  logic                                    i_pix_valid,
  output img_pkg::pixel_t [img_pkg::WIN_SIZE-1:0] o_column
);

  import img_pkg::*;

  localparam int N_LINES = WIN_SIZE - 1;

  // One frame row per line with the newest sample at index 0.
  pixel_t [FRAME_COLS-1:0] line_q [N_LINES];

  // ~~~~~~~~~~~~~~~~~~~~
  // Line buffer chain
  // ~~~~~~~~~~~~~~~~~~~~

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int k = 0; k < N_LINES; k++) begin
        line_q[k] <= '0;
      end
    end else if (i_pix_valid) begin
      line_q[0] <= {line_q[0][FRAME_COLS-2:0], i_pix};
      for (int k = 1; k < N_LINES; k++) begin
        // Oldest pixel of a line feeds the next line.
        line_q[k] <= {line_q[k][FRAME_COLS-2:0], line_q[k-1][FRAME_COLS-1]};
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~
  // Column taps
  // ~~~~~~~~~~~~~~~~~~~~

  // Index k is the pixel k rows above the current one.
  always_comb begin
    o_column[0] = i_pix;  // Current row.
    for (int k = 1; k < WIN_SIZE; k++) begin
      o_column[k] = line_q[k-1][FRAME_COLS-1];
    end
  end

  // Buffered rows must stay defined once the stream runs.
  a_taps_known : assert property (
    @(posedge clk) disable iff (!rst_n)
    i_pix_valid |-> !$isunknown(o_column)
  );

endmodule

`default_nettype wire

/* hw/ctrl_pkg.sv */
`default_nettype none

package ctrl_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Scan sequencing
  // ~~~~~~~~~~~~~~~~~~~~

  // FILL until the line buffers hold a full column.
  typedef enum logic [1:0] {
    IDLE,
    FILL,
    SCAN
  } scan_state_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Datapath controls
  // ~~~~~~~~~~~~~~~~~~~~

  // Aligned with the column sum they act on.
  typedef struct packed {
    logic ld;     // Restart accumulator with new column.
    logic sub;    // Drop the column 13 positions back.
    logic valid;  // Window is complete.
  } win_ctrl_t;

endpackage

`default_nettype wire

/* hw/img_pkg.sv */
`default_nettype none

package img_pkg;

  // ~~~~~~~~~~~~~~~~~~~~
  // Data widths
  // ~~~~~~~~~~~~~~~~~~~~

  typedef logic [7:0]  pixel_t;    // Grayscale sample.
  typedef logic [11:0] col_sum_t;  // Up to 3315 for 13 pixels.
  typedef logic [15:0] win_sum_t;  // Up to 43095 for 169 pixels.

  // Raster position counters.
  typedef logic [3:0] col_t;
  typedef logic [3:0] row_t;

  // ~~~~~~~~~~~~~~~~~~~~
  // Geometry
  // ~~~~~~~~~~~~~~~~~~~~

  localparam int FRAME_COLS = 16;
  localparam int FRAME_ROWS = 14;

  localparam int WIN_SIZE   = 13;  // Window side.
  localparam int WIN_RADIUS = 6;

  // Register stage on the taps plus four adder levels.
  localparam int COL_TREE_LAT = 5;

endpackage

`default_nettype wire
